// File: bench/tb_wr_chan.sv
module tb_wr_chan;

   import wr_chan_pkg::*;

   localparam int CLK_PERIOD   = 10;
   localparam int T2_WRITES    = 200;
   localparam int T3_TRANS     = 150;
   localparam int T5_WRITES    = 60;
   localparam int STIM_CYCLES  = 20 + 2 * (T2_WRITES + T3_TRANS) + 2 * (2**ADDR_W) + T5_WRITES;
   localparam int DRAIN_MARGIN = 500;

   typedef struct packed {
      logic [TAG_W-1:0]  tag;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } wr_rec_t;

   logic              clk;
   logic              rst;
   logic              wr_en;
   logic [HDR_W-1:0]  wr_hdr;
   logic [DATA_W-1:0] wr_data;
   logic              full;
   logic              sink_stall;
   logic              rsp_valid;
   logic [TAG_W-1:0]  rsp_tag;
   logic              fence_done;
   logic [ADDR_W-1:0] mem_raddr;
   logic [DATA_W-1:0] mem_rdata;
   logic              empty;
   logic [CNT_W-1:0]  count;
   logic              overflow;
   logic              underflow;
   logic              order_error;

   // Reference model
   wr_rec_t           exp_q [$];
   int                fence_q [$];
   logic [DATA_W-1:0] exp_mem [2**ADDR_W];
   bit                exp_wr [2**ADDR_W];
   logic [15:0]       lfsr;
   int                errors;
   int                tests_passed;
   int                writes_sent;
   int                fences_sent;
   int                fences_seen;
   int                rsp_seen;
   int                drops;
   bit                lossy;
   bit                full_seen;
   bit                order_reported;

   wr_chan_top u_dut (
      .clk         (clk),
      .rst         (rst),
      .wr_en       (wr_en),
      .wr_hdr      (wr_hdr),
      .wr_data     (wr_data),
      .full        (full),
      .sink_stall  (sink_stall),
      .rsp_valid   (rsp_valid),
      .rsp_tag     (rsp_tag),
      .fence_done  (fence_done),
      .mem_raddr   (mem_raddr),
      .mem_rdata   (mem_rdata),
      .empty       (empty),
      .count       (count),
      .overflow    (overflow),
      .underflow   (underflow),
      .order_error (order_error)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #((STIM_CYCLES * 4 + DRAIN_MARGIN) * CLK_PERIOD);
      $display("Watchdog expired at %0t, the channel did not drain in time", $time);
      $display("** FAIL **");
      $finish;
   end

   // Galois LFSR x^16 + x^14 + x^13 + x^11 + 1, one step per bit
   function automatic logic [DATA_W-1:0] take_bits(input int n);
      logic [DATA_W-1:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[DATA_W-2:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      end
      return v;
   endfunction

   task automatic report_value(input string msg);
      $display("FAILED at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic report_problem(input string msg);
      $display("Error at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic send_line(input tx_type_e kind, input logic [ADDR_W-1:0] addr,
                            input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
      wr_rec_t rec;
      rec.tag  = tag;
      rec.addr = addr;
      rec.data = data;
      wr_en   <= 1'b1;
      wr_hdr  <= {kind, addr, tag};
      wr_data <= data;
      exp_q.push_back(rec);
      exp_mem[addr] = data;
      exp_wr[addr]  = 1'b1;
      writes_sent++;
   endtask

   // Fence tags have the top bit set, line tags never do
   task automatic send_fence(input logic [ADDR_W-1:0] addr, input logic [TAG_W-1:0] tag);
      wr_en   <= 1'b1;
      wr_hdr  <= {TX_WRFENCE, addr, 1'b1, tag[TAG_W-2:0]};
      wr_data <= '0;
      fence_q.push_back(writes_sent);
      fences_sent++;
   endtask

   task automatic step_writer(input bit allow_fence, output bit issued);
      logic [ADDR_W-1:0] addr;
      logic [TAG_W-1:0]  tag;
      tx_type_e          kind;
      issued     = 1'b0;
      sink_stall <= (take_bits(2) == 64'd3);
      wr_en      <= 1'b0;
      if (!full && take_bits(1) == 64'd1) begin
         addr   = ADDR_W'(take_bits(ADDR_W));
         tag    = {1'b0, 7'(take_bits(TAG_W - 1))};
         issued = 1'b1;
         if (allow_fence && take_bits(3) == 64'd0) begin
            send_fence(addr, tag);
         end else begin
            kind = (allow_fence && take_bits(1) == 64'd1) ? TX_RSVD2 : TX_WRLINE;
            send_line(kind, addr, tag, take_bits(DATA_W));
         end
      end
   endtask

   // Idle until nothing is left in flight for a while
   task automatic drain(input bit need_model_empty);
      int quiet;
      quiet = 0;
      @(posedge clk);
      wr_en      <= 1'b0;
      sink_stall <= 1'b0;
      while (quiet < 12) begin
         @(posedge clk);
         if (empty && count == '0 && !rsp_valid && !fence_done &&
             (!need_model_empty || (exp_q.size() == 0 && fence_q.size() == 0))) begin
            quiet++;
         end else begin
            quiet = 0;
         end
      end
   endtask

   task automatic watch_outputs();
      forever begin
         @(posedge clk);
         if (!rst) begin
            if (fence_done) begin
               if (fence_q.size() == 0) begin
                  report_problem("fence_done pulsed with no fence outstanding");
               end else begin
                  assert (rsp_seen == fence_q[0]) else report_value($sformatf(
                     "fence done after %0d responses, expected %0d", rsp_seen, fence_q[0]));
                  void'(fence_q.pop_front());
                  fences_seen++;
               end
            end
            if (rsp_valid) begin
               assert (!rsp_tag[TAG_W-1]) else report_value($sformatf(
                  "response carries fence tag %02h", rsp_tag));
               // Dropped writes are skipped under overflow
               while (lossy && exp_q.size() > 0 && exp_q[0].tag != rsp_tag) begin
                  void'(exp_q.pop_front());
               end
               if (exp_q.size() == 0) begin
                  report_problem("a response arrived that matches no outstanding write");
               end else begin
                  assert (rsp_tag == exp_q[0].tag) else report_value($sformatf(
                     "response tag %02h, expected %02h", rsp_tag, exp_q[0].tag));
                  void'(exp_q.pop_front());
               end
               rsp_seen++;
            end
            if (overflow) begin
               if (lossy) begin
                  assert (full_seen) else report_problem("overflow pulsed before full rose");
                  drops++;
               end else begin
                  report_problem("overflow pulsed although the writer obeyed full");
               end
            end
            if (full) begin
               full_seen = 1'b1;
            end
            assert (!underflow) else report_problem("underflow pulsed");
            assert (!order_error || order_reported) else begin
               report_problem("order checker flagged a lost or reordered transaction");
               order_reported = 1'b1;
            end
         end
      end
   endtask

   task automatic finish_test(input int num, input string name, input int err_start);
      if (errors == err_start) begin
         $display("Test %0d %s: passed", num, name);
         tests_passed++;
      end else begin
         $display("Test %0d %s: failed with %0d errors", num, name, errors - err_start);
      end
   endtask

   initial begin
      int                err_start;
      int                rsp_start;
      int                issued_cnt;
      int                checked;
      bit                issued;
      logic [ADDR_W-1:0] addr;
      logic [TAG_W-1:0]  tag;
      lfsr           = 16'd48;
      errors         = 0;
      tests_passed   = 0;
      writes_sent    = 0;
      fences_sent    = 0;
      fences_seen    = 0;
      rsp_seen       = 0;
      drops          = 0;
      lossy          = 1'b0;
      full_seen      = 1'b0;
      order_reported = 1'b0;
      rst            = 1'b1;
      wr_en          = 1'b0;
      wr_hdr         = '0;
      wr_data        = '0;
      sink_stall     = 1'b0;
      mem_raddr      = '0;
      fork
         watch_outputs();
      join_none
      repeat (4) @(posedge clk);
      rst <= 1'b0;

      err_start = errors;
      repeat (16) begin
         @(posedge clk);
         assert (empty && count == '0 && !rsp_valid && !fence_done && !overflow &&
                 !underflow && !order_error) else report_value($sformatf(
            "idle outputs wrong, empty %b count %0d", empty, count));
      end
      finish_test(1, "reset state", err_start);

      err_start  = errors;
      rsp_start  = rsp_seen;
      issued_cnt = 0;
      while (issued_cnt < T2_WRITES) begin
         @(posedge clk);
         step_writer(1'b0, issued);
         if (issued) begin
            issued_cnt++;
         end
      end
      drain(1'b1);
      assert (rsp_seen - rsp_start == T2_WRITES) else report_value($sformatf(
         "%0d responses for %0d writes", rsp_seen - rsp_start, T2_WRITES));
      finish_test(2, "in-order writes", err_start);

      err_start  = errors;
      issued_cnt = 0;
      while (issued_cnt < T3_TRANS) begin
         @(posedge clk);
         step_writer(1'b1, issued);
         if (issued) begin
            issued_cnt++;
         end
      end
      drain(1'b1);
      assert (fences_sent > 0) else report_problem("no fence was generated");
      assert (fences_seen == fences_sent) else report_value($sformatf(
         "%0d fences completed, %0d sent", fences_seen, fences_sent));
      finish_test(3, "fence ordering", err_start);

      err_start = errors;
      checked   = 0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         addr = ADDR_W'(a);
         @(posedge clk);
         mem_raddr <= addr;
         @(posedge clk);
         if (exp_wr[addr]) begin
            assert (mem_rdata == exp_mem[addr]) else report_value($sformatf(
               "line %0d holds %016h, expected %016h", a, mem_rdata, exp_mem[addr]));
            checked++;
         end
      end
      assert (checked > 0) else report_problem("no line was written before the memory check");
      finish_test(4, "shadow memory", err_start);

      err_start = errors;
      rsp_start = rsp_seen;
      drops     = 0;
      full_seen = 1'b0;
      lossy     = 1'b1;
      // Writer ignores full while the sink is stalled
      for (int i = 0; i < T5_WRITES; i++) begin
         @(posedge clk);
         sink_stall <= 1'b1;
         addr = ADDR_W'(take_bits(ADDR_W));
         tag  = {1'b0, 7'(take_bits(TAG_W - 1))};
         send_line(TX_WRLINE, addr, tag, take_bits(DATA_W));
      end
      drain(1'b0);
      assert (drops > 0) else report_problem("no write was dropped under back-pressure");
      assert (rsp_seen - rsp_start == T5_WRITES - drops) else report_value($sformatf(
         "%0d responses, expected %0d", rsp_seen - rsp_start, T5_WRITES - drops));
      assert (!order_error) else report_problem("order_error is set at the end of the run");
      lossy = 1'b0;
      exp_q.delete();
      finish_test(5, "back-pressure and overflow", err_start);

      $display("Summary: %0d of 5 tests passed, %0d errors", tests_passed, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

// File: design/order_checker.sv
module order_checker (
   input  logic                          clk,
   input  logic                          rst,
   input  logic                          in_strobe,
   input  logic [wr_chan_pkg::TID_W-1:0] in_tid,
   input  logic                          fence_drop,
   input  logic                          out_valid,
   input  logic [wr_chan_pkg::TID_W-1:0] out_tid,
   output logic                          order_error
);

   import wr_chan_pkg::*;

   // Next ID due at the output, and one past the last ID issued
   logic [TID_W-1:0] exp_tid;
   logic [TID_W-1:0] issued_tid;
   logic             mismatch;
   logic             unissued;

   assign mismatch = out_valid && (out_tid != exp_tid);
   assign unissued = out_valid && (out_tid >= issued_tid);

   always_ff @(posedge clk) begin
      if (rst) begin
         exp_tid     <= '0;
         issued_tid  <= '0;
         order_error <= 1'b0;
      end else begin
         if (in_strobe) begin
            issued_tid <= in_tid + TID_W'(1);
         end
         // A dropped fence consumes its ID without an output
         if (out_valid || fence_drop) begin
            exp_tid <= exp_tid + TID_W'(1);
         end
         if (mismatch || unissued) begin
            order_error <= 1'b1;
         end
      end
   end

   // One ID per cycle, a fence drop never coincides with an output
   a_single_id_per_cycle: assert property (
      @(posedge clk) disable iff (rst)
      !(out_valid && fence_drop)
   );

endmodule

// File: design/sync_fifo.sv
module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_LOG2 = 4,
   parameter int ALMFULL    = 12
) (
   input  logic                clk,
   input  logic                rst,
   input  logic                wr_en,
   input  logic [WIDTH-1:0]    data_in,
   input  logic                rd_en,
   output logic [WIDTH-1:0]    data_out,
   output logic                data_out_v,
   output logic                alm_full,
   output logic                empty,
   output logic [DEPTH_LOG2:0] count,
   output logic                overflow,
   output logic                underflow
);

   logic [WIDTH-1:0]      mem [2**DEPTH_LOG2];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   occ;
   logic                  full;
   logic                  do_wr;
   logic                  do_rd;

   // MSB of the occupancy is set only with all entries in use
   assign full     = occ[DEPTH_LOG2];
   assign empty    = (occ == '0);
   assign alm_full = (occ >= (DEPTH_LOG2+1)'(ALMFULL));
   assign count    = occ;

   assign do_wr = wr_en && !full;
   assign do_rd = rd_en && !empty;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= data_in;
      end
      if (do_rd) begin
         data_out <= mem[rd_ptr];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         occ        <= '0;
         data_out_v <= 1'b0;
         overflow   <= 1'b0;
         underflow  <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + DEPTH_LOG2'(1);
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + DEPTH_LOG2'(1);
         end
         case ({do_wr, do_rd})
            2'b10:   occ <= occ + (DEPTH_LOG2+1)'(1);
            2'b01:   occ <= occ - (DEPTH_LOG2+1)'(1);
            default: occ <= occ;
         endcase
         data_out_v <= do_rd;
         // Rejected accesses
         overflow   <= wr_en && full;
         underflow  <= rd_en && empty;
      end
   end

   // Occupancy never exceeds the buffer depth
   a_occ_in_range: assert property (
      @(posedge clk) disable iff (rst)
      occ <= (DEPTH_LOG2+1)'(2**DEPTH_LOG2)
   );

endmodule

// File: design/wr_chan_pkg.sv
package wr_chan_pkg;

   // Header is {type, cache-line address, request tag}
   localparam int HDR_W   = 16;
   localparam int TYPE_LO = 14;
   localparam int TYPE_HI = 15;
   localparam int ADDR_LO = 8;
   localparam int ADDR_HI = 13;
   localparam int TAG_LO  = 0;
   localparam int TAG_HI  = 7;

   localparam int DATA_W = 64;
   localparam int TID_W  = 16;
   localparam int ADDR_W = 6;
   localparam int TAG_W  = 8;

   // Input FIFO models the host visible queue depth
   localparam int IN_DEPTH_LOG2 = 5;
   localparam int IN_ALMFULL    = 24;

   localparam int OUT_DEPTH_LOG2 = 3;
   localparam int OUT_ALMFULL    = 5;

   // Sum of both FIFO counts, up to 40 entries
   localparam int CNT_W = 7;

   // Reserved codes behave as line writes
   typedef enum logic [1:0] {
      TX_WRLINE  = 2'b00,
      TX_WRFENCE = 2'b01,
      TX_RSVD2   = 2'b10,
      TX_RSVD3   = 2'b11
   } tx_type_e;

   typedef enum logic [1:0] {
      WRF_PASS   = 2'b00,
      WRF_WAIT   = 2'b01,
      WRF_SETTLE = 2'b10
   } wrf_state_e;

endpackage

// File: design/wr_chan_top.sv
module wr_chan_top (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           wr_en,
   input  logic [wr_chan_pkg::HDR_W-1:0]  wr_hdr,
   input  logic [wr_chan_pkg::DATA_W-1:0] wr_data,
   output logic                           full,
   input  logic                           sink_stall,
   output logic                           rsp_valid,
   output logic [wr_chan_pkg::TAG_W-1:0]  rsp_tag,
   output logic                           fence_done,
   input  logic [wr_chan_pkg::ADDR_W-1:0] mem_raddr,
   output logic [wr_chan_pkg::DATA_W-1:0] mem_rdata,
   output logic                           empty,
   output logic [wr_chan_pkg::CNT_W-1:0]  count,
   output logic                           overflow,
   output logic                           underflow,
   output logic                           order_error
);

   import wr_chan_pkg::*;

   logic              pop;
   logic [HDR_W-1:0]  out_hdr;
   logic [DATA_W-1:0] out_data;
   logic              out_valid;
   logic [TID_W-1:0]  in_tid;
   logic [TID_W-1:0]  out_tid;

   wrfence_channel u_chan (
      .clk        (clk),
      .rst        (rst),
      .wr_en      (wr_en),
      .wr_hdr     (wr_hdr),
      .wr_data    (wr_data),
      .full       (full),
      .pop        (pop),
      .out_hdr    (out_hdr),
      .out_data   (out_data),
      .out_valid  (out_valid),
      .out_empty  (empty),
      .in_tid     (in_tid),
      .out_tid    (out_tid),
      .fence_done (fence_done),
      .count      (count),
      .overflow   (overflow),
      .underflow  (underflow)
   );

   order_checker u_chk (
      .clk         (clk),
      .rst         (rst),
      .in_strobe   (wr_en),
      .in_tid      (in_tid),
      .fence_drop  (fence_done),
      .out_valid   (out_valid),
      .out_tid     (out_tid),
      .order_error (order_error)
   );

   wr_mem_sink u_sink (
      .clk        (clk),
      .rst        (rst),
      .out_empty  (empty),
      .sink_stall (sink_stall),
      .pop        (pop),
      .out_valid  (out_valid),
      .out_hdr    (out_hdr),
      .out_data   (out_data),
      .rsp_valid  (rsp_valid),
      .rsp_tag    (rsp_tag),
      .mem_raddr  (mem_raddr),
      .mem_rdata  (mem_rdata)
   );

endmodule

// File: design/wr_mem_sink.sv
module wr_mem_sink (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           out_empty,
   input  logic                           sink_stall,
   output logic                           pop,
   input  logic                           out_valid,
   input  logic [wr_chan_pkg::HDR_W-1:0]  out_hdr,
   input  logic [wr_chan_pkg::DATA_W-1:0] out_data,
   output logic                           rsp_valid,
   output logic [wr_chan_pkg::TAG_W-1:0]  rsp_tag,
   input  logic [wr_chan_pkg::ADDR_W-1:0] mem_raddr,
   output logic [wr_chan_pkg::DATA_W-1:0] mem_rdata
);

   import wr_chan_pkg::*;

   logic [DATA_W-1:0] shadow [2**ADDR_W];
   logic [ADDR_W-1:0] line_addr;

   // Occupancy is registered, so this never pops an empty FIFO
   assign pop = !out_empty && !sink_stall;

   assign line_addr = out_hdr[ADDR_HI:ADDR_LO];

   always_ff @(posedge clk) begin
      if (out_valid) begin
         shadow[line_addr] <= out_data;
         rsp_tag           <= out_hdr[TAG_HI:TAG_LO];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= out_valid;
      end
   end

   assign mem_rdata = shadow[mem_raddr];

endmodule

// File: design/wrfence_channel.sv
module wrfence_channel (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           wr_en,
   input  logic [wr_chan_pkg::HDR_W-1:0]  wr_hdr,
   input  logic [wr_chan_pkg::DATA_W-1:0] wr_data,
   output logic                           full,
   input  logic                           pop,
   output logic [wr_chan_pkg::HDR_W-1:0]  out_hdr,
   output logic [wr_chan_pkg::DATA_W-1:0] out_data,
   output logic                           out_valid,
   output logic                           out_empty,
   output logic [wr_chan_pkg::TID_W-1:0]  in_tid,
   output logic [wr_chan_pkg::TID_W-1:0]  out_tid,
   output logic                           fence_done,
   output logic [wr_chan_pkg::CNT_W-1:0]  count,
   output logic                           overflow,
   output logic                           underflow
);

   import wr_chan_pkg::*;

   logic [TID_W+HDR_W+DATA_W-1:0] in_dout;
   logic                          in_valid;
   logic                          in_pop;
   logic                          in_empty;
   logic [IN_DEPTH_LOG2:0]        in_count;
   logic                          in_ovf;
   logic                          in_udf;

   logic                          head_hold;
   logic                          head_valid;
   logic                          head_take;
   logic                          line_take;
   logic                          fence_head;
   logic [HDR_W-1:0]              head_hdr;
   tx_type_e                      head_type;

   logic [TID_W+HDR_W+DATA_W-1:0] xfer_din;
   logic [HDR_W-1:0]              xfer_hdr;
   logic                          xfer_wen;

   logic                          out_alm_full;
   logic [OUT_DEPTH_LOG2:0]       out_count;
   logic                          out_ovf;
   logic                          out_udf;

   wrf_state_e                    wrf_state;

   // Running tracking ID, only consumed by writes the input FIFO accepts
   always_ff @(posedge clk) begin
      if (rst) begin
         in_tid <= '0;
      end else if (wr_en && !in_count[IN_DEPTH_LOG2]) begin
         in_tid <= in_tid + TID_W'(1);
      end
   end

   sync_fifo #(
      .WIDTH      (TID_W + HDR_W + DATA_W),
      .DEPTH_LOG2 (IN_DEPTH_LOG2),
      .ALMFULL    (IN_ALMFULL)
   ) in_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_en      (wr_en),
      .data_in    ({in_tid, wr_hdr, wr_data}),
      .rd_en      (in_pop),
      .data_out   (in_dout),
      .data_out_v (in_valid),
      .alm_full   (full),
      .empty      (in_empty),
      .count      (in_count),
      .overflow   (in_ovf),
      .underflow  (in_udf)
   );

   // FIFO output register acts as the head slot of the input queue
   assign head_valid = in_valid || head_hold;
   assign head_hdr   = in_dout[DATA_W +: HDR_W];
   assign head_type  = tx_type_e'(head_hdr[TYPE_HI:TYPE_LO]);
   assign fence_head = head_valid && (head_type == TX_WRFENCE);
   assign line_take  = head_valid && !fence_head && !out_alm_full;
   assign head_take  = line_take || fence_done;
   assign in_pop     = !in_empty && (!head_valid || head_take);

   always_ff @(posedge clk) begin
      if (rst) begin
         head_hold <= 1'b0;
         xfer_wen  <= 1'b0;
      end else begin
         head_hold <= head_valid && !head_take;
         xfer_wen  <= line_take;
      end
   end

   always_ff @(posedge clk) begin
      if (line_take) begin
         xfer_din <= in_dout;
      end
   end

   assign xfer_hdr = xfer_din[DATA_W +: HDR_W];

   // Fence trap, fence_done marks the cycle the fence is dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         wrf_state  <= WRF_PASS;
         fence_done <= 1'b0;
      end else begin
         fence_done <= 1'b0;
         case (wrf_state)
            WRF_PASS: begin
               if (fence_head) begin
                  wrf_state <= WRF_WAIT;
               end
            end
            WRF_WAIT: begin
               // Also wait out a write in transfer or one just popped
               if (out_empty && !xfer_wen && !out_valid) begin
                  fence_done <= 1'b1;
                  wrf_state  <= WRF_SETTLE;
               end
            end
            WRF_SETTLE: wrf_state <= WRF_PASS;
            default:    wrf_state <= WRF_PASS;
         endcase
      end
   end

   sync_fifo #(
      .WIDTH      (TID_W + HDR_W + DATA_W),
      .DEPTH_LOG2 (OUT_DEPTH_LOG2),
      .ALMFULL    (OUT_ALMFULL)
   ) out_fifo (
      .clk        (clk),
      .rst        (rst),
      .wr_en      (xfer_wen),
      .data_in    (xfer_din),
      .rd_en      (pop),
      .data_out   ({out_tid, out_hdr, out_data}),
      .data_out_v (out_valid),
      .alm_full   (out_alm_full),
      .empty      (out_empty),
      .count      (out_count),
      .overflow   (out_ovf),
      .underflow  (out_udf)
   );

   assign count     = CNT_W'(in_count) + CNT_W'(out_count);
   assign overflow  = in_ovf || out_ovf;
   assign underflow = in_udf || out_udf;

   a_no_fence_forwarded: assert property (
      @(posedge clk) disable iff (rst)
      xfer_wen |-> (tx_type_e'(xfer_hdr[TYPE_HI:TYPE_LO]) != TX_WRFENCE)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_wr_chan -Mdir obj_dir -f vlog.f
./obj_dir/Vtb_wr_chan | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
   echo "simulation passed"
else
   echo "simulation failed, see sim.log"
   exit 1
fi

// File: vlog.f
design/wr_chan_pkg.sv
design/sync_fifo.sv
design/wrfence_channel.sv
design/order_checker.sv
design/wr_mem_sink.sv
design/wr_chan_top.sv
bench/tb_wr_chan.sv
